// File: vlog.f
+incdir+testbench
common/ctrlport_pkg.sv
common/timing_pkg.sv
src/ctrlport_window.sv
src/ctrlport_timekeeper.sv
timed_gate/ctrlport_timed_gate.sv
src/ctrlport_reg_bank.sv
src/ctrlport_subsystem.sv
testbench/tb_ctrlport_subsystem.sv

// File: Bender.yml
package:
  name: ctrlport_subsystem

sources:
  - files:
      - common/ctrlport_pkg.sv
      - common/timing_pkg.sv
      - src/ctrlport_window.sv
      - src/ctrlport_timekeeper.sv
      - timed_gate/ctrlport_timed_gate.sv
      - src/ctrlport_reg_bank.sv
      - src/ctrlport_subsystem.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ctrlport_subsystem.sv

// File: testbench/tb_tasks.svh
task automatic expect_equal(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
  if (expected !== actual) begin
    $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
    error_count++;
  end
endtask

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0] byte_en);
  logic [31:0] result;
  int b;
  result = old_word;
  for (b = 0; b < 4; b++) begin
    if (byte_en[b]) result[8*b +: 8] = new_word[8*b +: 8];
  end
  return result;
endfunction

function automatic logic [19:0] reg_addr(input int index);
  // Indices past bank A continue in bank B
  if (index < NUM_A) return 20'(BASE_A + 4 * index);
  return 20'(BASE_B + 4 * (index - NUM_A));
endfunction

function automatic logic [31:0] model_read(input logic [19:0] addr);
  if (addr >= BASE_B) return model_b[(addr - BASE_B) / 4];
  return model_a[(addr - BASE_A) / 4];
endfunction

task automatic model_write(input logic [19:0] addr, input logic [31:0] data,
                           input logic [3:0] byte_en);
  if (addr >= BASE_B) begin
    model_b[(addr - BASE_B) / 4] = merge_bytes(model_b[(addr - BASE_B) / 4], data, byte_en);
  end else begin
    model_a[(addr - BASE_A) / 4] = merge_bytes(model_a[(addr - BASE_A) / 4], data, byte_en);
  end
endtask

// Sends one request and waits for its ack
// Cycles counts the clock edges after the edge that samples the strobe
task automatic send_request(input logic wr, input logic [19:0] addr,
                            input logic [31:0] data, input logic [3:0] byte_en,
                            input logic timed, input time_t stamp,
                            output ctrlport_resp_t resp, output int cycles,
                            output time_t ack_time);
  @(negedge ctrlport_clk);
  s_req            = '0;
  s_req.wr         = wr;
  s_req.rd         = !wr;
  s_req.addr       = addr;
  s_req.portid     = 10'h3;
  s_req.rem_epid   = 16'h1;
  s_req.data       = data;
  s_req.byte_en    = byte_en;
  s_req.has_time   = timed;
  s_req.timestamp  = stamp;
  @(negedge ctrlport_clk);
  s_req.wr = 1'b0;
  s_req.rd = 1'b0;
  cycles = 0;
  while (!s_resp.ack && cycles < ACK_LIMIT) begin
    @(negedge ctrlport_clk);
    cycles++;
  end
  resp     = s_resp;
  ack_time = time_now;
  if (!s_resp.ack) begin
    $display("No acknowledge for address %0h within %0d cycles", addr, ACK_LIMIT);
    error_count++;
  end
endtask

task automatic read_and_compare(input logic [19:0] addr);
  ctrlport_resp_t resp;
  int cycles;
  time_t ack_time;
  send_request(1'b0, addr, '0, 4'hf, 1'b0, '0, resp, cycles, ack_time);
  expect_equal("s_resp.status", STS_OKAY, resp.status);
  expect_equal("s_resp.data", model_read(addr), resp.data);
  expect_equal("ack latency", 3, cycles);
endtask

task automatic load_time(input time_t value);
  @(negedge ctrlport_clk);
  time_set_stb   = 1'b1;
  time_set_value = value;
  @(negedge ctrlport_clk);
  time_set_stb = 1'b0;
  expect_equal("time_now", value, time_now);
endtask

task automatic write_readback();
  ctrlport_resp_t resp;
  int cycles;
  time_t ack_time;
  logic [31:0] data;
  for (int i = 0; i < NUM_A + NUM_B; i++) begin
    data = $urandom;
    send_request(1'b1, reg_addr(i), data, 4'hf, 1'b0, '0, resp, cycles, ack_time);
    expect_equal("s_resp.status", STS_OKAY, resp.status);
    expect_equal("ack latency", 3, cycles);
    model_write(reg_addr(i), data, 4'hf);
  end
  for (int i = 0; i < NUM_A + NUM_B; i++) read_and_compare(reg_addr(i));
endtask

task automatic byte_enable_writes();
  ctrlport_resp_t resp;
  int cycles;
  time_t ack_time;
  logic [19:0] addr;
  logic [31:0] data;
  logic [3:0] byte_en;
  repeat (12) begin
    addr    = reg_addr($urandom_range(NUM_A + NUM_B - 1));
    data    = $urandom;
    byte_en = 4'($urandom);
    send_request(1'b1, addr, data, byte_en, 1'b0, '0, resp, cycles, ack_time);
    expect_equal("s_resp.status", STS_OKAY, resp.status);
    model_write(addr, data, byte_en);
    read_and_compare(addr);
  end
endtask

task automatic unmapped_access();
  ctrlport_resp_t resp;
  int cycles;
  time_t ack_time;
  logic [19:0] holes [2];
  // Gap between the windows, then above window B
  holes[0] = 20'h00080;
  holes[1] = 20'h00200;
  foreach (holes[h]) begin
    send_request(1'b1, holes[h], $urandom, 4'hf, 1'b0, '0, resp, cycles, ack_time);
    expect_equal("s_resp.status", STS_CMDERR, resp.status);
    expect_equal("s_resp.data", 0, resp.data);
    send_request(1'b0, holes[h], '0, 4'hf, 1'b0, '0, resp, cycles, ack_time);
    expect_equal("s_resp.status", STS_CMDERR, resp.status);
    expect_equal("s_resp.data", 0, resp.data);
  end
  for (int i = 0; i < NUM_A + NUM_B; i++) read_and_compare(reg_addr(i));
endtask

task automatic late_timed_command();
  ctrlport_resp_t resp;
  int cycles;
  time_t ack_time;
  load_time(64'd5000);
  send_request(1'b1, 20'(BASE_B + 8), $urandom, 4'hf, 1'b1, time_now - 64'd100,
               resp, cycles, ack_time);
  expect_equal("s_resp.status", STS_TSERR, resp.status);
  read_and_compare(20'(BASE_B + 8));
endtask

task automatic future_timed_command();
  ctrlport_resp_t resp;
  int cycles;
  time_t ack_time;
  time_t stamp;
  logic [31:0] data;
  load_time(64'h0000_0001_0000_0000);
  stamp = time_now + 64'd40;
  data  = $urandom;
  send_request(1'b1, 20'(BASE_A + 12), data, 4'hf, 1'b1, stamp, resp, cycles, ack_time);
  expect_equal("s_resp.status", STS_OKAY, resp.status);
  if (ack_time < stamp) begin
    $display("[ERROR] %0t time_now at ack expected >= %0h got %0h", $time, stamp, ack_time);
    error_count++;
  end
  model_write(20'(BASE_A + 12), data, 4'hf);
  read_and_compare(20'(BASE_A + 12));
endtask

task automatic report_test(input string name, input int errors_before);
  tests_run++;
  if (error_count == errors_before) begin
    $display("PASS %s", name);
  end else begin
    tests_failed++;
    $display("FAIL %s (%0d errors)", name, error_count - errors_before);
  end
endtask

// File: testbench/tb_ctrlport_subsystem.sv
module tb_ctrlport_subsystem
  import ctrlport_pkg::*;
  import timing_pkg::*;
;

  localparam int CLK_PERIOD = 20;
  localparam int BASE_A     = 'h0000;
  localparam int SIZE_A     = 32;
  localparam int BASE_B     = 'h0100;
  localparam int SIZE_B     = 64;
  localparam int NUM_A      = SIZE_A / 4;
  localparam int NUM_B      = SIZE_B / 4;
  // Longest wait for one ack, covers the 40-tick timed wait and the unmapped timeout
  localparam int ACK_LIMIT  = 64;
  // Requests per test: 48 + 24 + 28 + 2 + 2
  localparam int NUM_REQUESTS  = 104;
  localparam int WORST_CYCLES  = 10 + NUM_REQUESTS * (ACK_LIMIT + 2) + 8;
  localparam int WATCHDOG_TIME = 2 * WORST_CYCLES * CLK_PERIOD;

  logic           ctrlport_clk = 1'b0;
  logic           rst_n;
  ctrlport_req_t  s_req;
  ctrlport_resp_t s_resp;
  logic           time_set_stb;
  time_t          time_set_value;
  time_t          time_now;

  int error_count  = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  // Expected register contents
  logic [31:0] model_a [NUM_A];
  logic [31:0] model_b [NUM_B];

  always #(CLK_PERIOD / 2) ctrlport_clk = ~ctrlport_clk;

  ctrlport_subsystem #(
    .BASE_A         (BASE_A),
    .SIZE_A         (SIZE_A),
    .BASE_B         (BASE_B),
    .SIZE_B         (SIZE_B),
    .TIMEOUT_CYCLES (16)
  ) dut (
    .ctrlport_clk   (ctrlport_clk),
    .rst_n          (rst_n),
    .s_req          (s_req),
    .s_resp         (s_resp),
    .time_set_stb   (time_set_stb),
    .time_set_value (time_set_value),
    .time_now       (time_now)
  );

  `include "tb_tasks.svh"

  initial begin
    int errors_before;
    void'($urandom(32'hd511));
    s_req          = '0;
    time_set_stb   = 1'b0;
    time_set_value = '0;
    rst_n          = 1'b0;
    for (int i = 0; i < NUM_A; i++) model_a[i] = '0;
    for (int i = 0; i < NUM_B; i++) model_b[i] = '0;
    repeat (10) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    rst_n = 1'b1;

    errors_before = error_count;
    write_readback();
    report_test("untimed write and readback", errors_before);
    errors_before = error_count;
    byte_enable_writes();
    report_test("byte-enable writes", errors_before);
    errors_before = error_count;
    unmapped_access();
    report_test("unmapped address", errors_before);
    errors_before = error_count;
    late_timed_command();
    report_test("late timed command", errors_before);
    errors_before = error_count;
    future_timed_command();
    report_test("future timed command", errors_before);

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Ends a run that hangs
  initial begin
    #(WATCHDOG_TIME);
    $display("Run did not finish within %0d time units", WATCHDOG_TIME);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: src/ctrlport_subsystem.sv
module ctrlport_subsystem
  import ctrlport_pkg::*;
  import timing_pkg::*;
#(
  parameter int BASE_A         = 'h0000,
  parameter int SIZE_A         = 32,
  parameter int BASE_B         = 'h0100,
  parameter int SIZE_B         = 64,
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic           ctrlport_clk,
  input  logic           rst_n,
  // Upstream control port
  input  ctrlport_req_t  s_req,
  output ctrlport_resp_t s_resp,
  // Time load and readout
  input  logic           time_set_stb,
  input  time_t          time_set_value,
  output time_t          time_now
);

  // One 32-bit register per word of each window
  localparam int REGS_A = SIZE_A / 4;
  localparam int REGS_B = SIZE_B / 4;

  time_t          now_time;
  ctrlport_req_t  gate_req;
  ctrlport_req_t  req_a;
  ctrlport_req_t  req_b;
  ctrlport_resp_t resp_a;
  ctrlport_resp_t resp_b;

  ctrlport_timekeeper u_timekeeper (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .set_stb      (time_set_stb),
    .set_value    (time_set_value),
    .now_time     (now_time)
  );

  assign time_now = now_time;

  ctrlport_timed_gate #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_gate (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_resp       (s_resp),
    .now_time     (now_time),
    .m_req        (gate_req),
    .resp_a       (resp_a),
    .resp_b       (resp_b)
  );

  // The gate merges the bank responses itself
  ctrlport_window #(
    .BASE_ADDRESS (BASE_A),
    .WINDOW_SIZE  (SIZE_A)
  ) u_window_a (
    .s_req  (gate_req),
    .s_resp (),
    .m_req  (req_a),
    .m_resp (resp_a)
  );

  ctrlport_window #(
    .BASE_ADDRESS (BASE_B),
    .WINDOW_SIZE  (SIZE_B)
  ) u_window_b (
    .s_req  (gate_req),
    .s_resp (),
    .m_req  (req_b),
    .m_resp (resp_b)
  );

  ctrlport_reg_bank #(
    .NUM_REGS (REGS_A)
  ) u_bank_a (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req_a),
    .resp         (resp_a)
  );

  ctrlport_reg_bank #(
    .NUM_REGS (REGS_B)
  ) u_bank_b (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req_b),
    .resp         (resp_b)
  );

endmodule

// File: src/ctrlport_reg_bank.sv
module ctrlport_reg_bank
  import ctrlport_pkg::*;
#(
  parameter int NUM_REGS = 8
) (
  input  logic           ctrlport_clk,
  input  logic           rst_n,
  input  ctrlport_req_t  req,
  output ctrlport_resp_t resp
);

  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic [IDX_W-1:0]  idx;

  // Word index, base is aligned to the window size
  assign idx = req.addr[2 +: IDX_W];

  // Register file with byte-enable writes
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (req.wr) begin
      for (int b = 0; b < BYTE_W; b++) begin
        if (req.byte_en[b]) begin
          regs[idx][8*b +: 8] <= req.data[8*b +: 8];
        end
      end
    end
  end

  // Ack one cycle after either strobe
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      resp <= '0;
    end else begin
      resp.ack    <= req.wr | req.rd;
      resp.status <= STS_OKAY;
      // Write acks carry zero data
      if (req.rd) begin
        resp.data <= regs[idx];
      end else begin
        resp.data <= '0;
      end
    end
  end

endmodule

// File: timed_gate/ctrlport_timed_gate.sv
module ctrlport_timed_gate
  import ctrlport_pkg::*;
  import timing_pkg::*;
#(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic           ctrlport_clk,
  input  logic           rst_n,
  // Upstream master
  input  ctrlport_req_t  s_req,
  output ctrlport_resp_t s_resp,
  // Current time from the timekeeper
  input  time_t          now_time,
  // Issued request and the bank responses
  output ctrlport_req_t  m_req,
  input  ctrlport_resp_t resp_a,
  input  ctrlport_resp_t resp_b
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  gate_state_t      state;
  ctrlport_req_t    req_q;
  ctrlport_resp_t   resp_q;
  ctrlport_resp_t   merged_resp;
  logic [CNT_W-1:0] wait_cnt;
  logic             new_req;
  logic             is_late;
  logic             is_future;
  logic             time_reached;
  logic             timed_out;

  assign new_req = s_req.wr | s_req.rd;

  // Timestamp checks at capture
  assign is_late   = s_req.has_time && (s_req.timestamp < now_time);
  assign is_future = s_req.has_time && (s_req.timestamp > now_time);

  // Greater-or-equal also covers a forward jump of the timekeeper
  assign time_reached = (now_time >= req_q.timestamp);

  assign timed_out = (wait_cnt == CNT_W'(TIMEOUT_CYCLES - 1));

  // Windows never overlap, so at most one bank drives a nonzero response
  assign merged_resp = ctrlport_resp_t'(resp_a | resp_b);

  // Issue strobe is high for the single ISSUE cycle
  always_comb begin
    m_req    = req_q;
    m_req.wr = req_q.wr & (state == ISSUE);
    m_req.rd = req_q.rd & (state == ISSUE);
  end

  // Request capture
  always_ff @(posedge ctrlport_clk) begin
    if (state == IDLE && new_req) begin
      req_q <= s_req;
    end
  end

  // Response to be returned in RESPOND
  always_ff @(posedge ctrlport_clk) begin
    if (state == IDLE && new_req && is_late) begin
      resp_q <= '{ack: 1'b1, status: STS_TSERR, data: '0};
    end else if (state == WAIT_ACK) begin
      if (merged_resp.ack) begin
        resp_q <= merged_resp;
      end else if (timed_out) begin
        // Nobody answered, the address is unmapped
        resp_q <= '{ack: 1'b1, status: STS_CMDERR, data: '0};
      end
    end
  end

  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      wait_cnt <= '0;
      s_resp   <= '0;
    end else begin
      s_resp <= '0;
      case (state)
        IDLE: begin
          wait_cnt <= '0;
          if (new_req) begin
            if (is_late) begin
              state <= RESPOND;
            end else if (is_future) begin
              state <= WAIT_TIME;
            end else begin
              state <= ISSUE;
            end
          end
        end
        WAIT_TIME: begin
          if (time_reached) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          wait_cnt <= '0;
          state    <= WAIT_ACK;
        end
        WAIT_ACK: begin
          if (merged_resp.ack || timed_out) begin
            state <= RESPOND;
          end else begin
            wait_cnt <= wait_cnt + CNT_W'(1);
          end
        end
        RESPOND: begin
          // One-cycle ack upstream
          s_resp <= resp_q;
          state  <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/ctrlport_timekeeper.sv
module ctrlport_timekeeper
  import timing_pkg::*;
(
  input  logic  ctrlport_clk,
  input  logic  rst_n,
  // Software load of the current time
  input  logic  set_stb,
  input  time_t set_value,
  output time_t now_time
);

  time_t count;

  // Counts every clock, a load takes priority
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (set_stb) begin
      count <= set_value;
    end else begin
      count <= count + time_t'(1);
    end
  end

  assign now_time = count;

endmodule

// File: src/ctrlport_window.sv
module ctrlport_window
  import ctrlport_pkg::*;
#(
  parameter int BASE_ADDRESS = 0,
  parameter int WINDOW_SIZE  = 32
) (
  // Upstream side
  input  ctrlport_req_t  s_req,
  output ctrlport_resp_t s_resp,
  // Downstream side
  output ctrlport_req_t  m_req,
  input  ctrlport_resp_t m_resp
);

  logic in_range;

  // Half-open range check on the byte address
  assign in_range = (s_req.addr >= BASE_ADDRESS) &&
                    (s_req.addr < BASE_ADDRESS + WINDOW_SIZE);

  always_comb begin
    m_req    = s_req;
    // Only the strobes are masked
    m_req.wr = s_req.wr & in_range;
    m_req.rd = s_req.rd & in_range;
  end

  // Response goes back untouched
  assign s_resp = m_resp;

endmodule

// File: common/timing_pkg.sv
package timing_pkg;

  // Free-running time word
  typedef logic [63:0] time_t;

  // Timed gate FSM states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    // Request accepted, waiting for its timestamp
    WAIT_TIME = 3'd1,
    // One-cycle strobe towards the windows
    ISSUE     = 3'd2,
    // Waiting for a bank ack or the timeout
    WAIT_ACK  = 3'd3,
    // Upstream ack cycle
    RESPOND   = 3'd4
  } gate_state_t;

endpackage

// File: common/ctrlport_pkg.sv
package ctrlport_pkg;

  // Field widths of the control-port bus
  localparam int ADDR_W = 20;
  localparam int DATA_W = 32;
  localparam int BYTE_W = DATA_W / 8;

  // Response status codes
  typedef enum logic [1:0] {
    STS_OKAY    = 2'd0,
    STS_CMDERR  = 2'd1,
    STS_TSERR   = 2'd2,
    STS_WARNING = 2'd3
  } ctrlport_status_t;

  // One request word, strobes first
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [9:0]        portid;
    logic [15:0]       rem_epid;
    logic [9:0]        rem_portid;
    logic [DATA_W-1:0] data;
    logic [BYTE_W-1:0] byte_en;
    logic              has_time;
    // Execution time, compared against the timekeeper
    logic [63:0]       timestamp;
  } ctrlport_req_t;

  // Response word, valid while ack is high
  typedef struct packed {
    logic              ack;
    ctrlport_status_t  status;
    logic [DATA_W-1:0] data;
  } ctrlport_resp_t;

endpackage
